/* logic/soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// ##########################################################
// bus widths
// ##########################################################

`define SOC_DATA_W		16		// data word
`define SOC_ADR_W		15		// word address, byte address bits 15..1
`define SOC_SEL_W		2		// one select per byte lane

// ##########################################################
// memories
// ##########################################################

`define SOC_RAM_ADR_W	13		// 8K words per block

// ##########################################################
// general-purpose port
// ##########################################################

`define SOC_GPIO_IN_W	3		// miso, wp, cd

// ##########################################################
// address map
// ##########################################################

`define SOC_REGION_RAM0	2'b00		// 0000-3FFF program memory
`define SOC_REGION_RAM1	2'b11		// C000-FFFF video memory
`define SOC_GPIO_PAGE	12'hB01		// B010-B013 port registers

`endif

/* logic/bus_pkg.sv */
`include "soc_config.svh"

package bus_pkg;

	// ##########################################################
	// system bus payload
	// ##########################################################

	typedef logic [`SOC_ADR_W-1:0]		adr_t;		// word address
	typedef logic [`SOC_DATA_W-1:0]		dat_t;
	typedef logic [`SOC_SEL_W-1:0]		sel_t;		// bit 1 high byte, bit 0 low byte

	// address as seen by one memory block
	typedef logic [`SOC_RAM_ADR_W-1:0]	ram_adr_t;

	// ##########################################################
	// port registers
	// ##########################################################

	// picked by byte address bit 1
	typedef enum logic {
		GPIO_IN		= 1'b0,		// B010, sensed pins
		GPIO_OUT	= 1'b1		// B012, output latch
	} gpio_reg_e;

endpackage

/* logic/map_pkg.sv */
package map_pkg;

	// ##########################################################
	// decode targets
	// ##########################################################

	// which slave a bus cycle lands on; TGT_NONE covers every hole
	// in the map, including the old keyboard page at B000
	typedef enum logic [1:0] {
		TGT_NONE	= 2'd0,		// unmapped, answered by the decoder
		TGT_PROGMEM	= 2'd1,		// 0000-3FFF
		TGT_GPIO	= 2'd2,		// B010-B013
		TGT_VIDMEM	= 2'd3		// C000-FFFF
	} target_e;

endpackage

/* logic/bus_decoder.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module bus_decoder (
	input  logic				cyc_i,
	input  logic				stb_i,
	input  bus_pkg::adr_t		adr_i,

	input  bus_pkg::dat_t		progmem_dat_i,
	input  bus_pkg::dat_t		vidmem_dat_i,
	input  bus_pkg::dat_t		gpio_dat_i,
	input  logic				progmem_ack_i,
	input  logic				vidmem_ack_i,
	input  logic				gpio_ack_i,

	output logic				progmem_stb_o,
	output logic				vidmem_stb_o,
	output logic				gpio_stb_o,
	output bus_pkg::dat_t		dat_o,
	output logic				ack_o
);

	localparam int REGION_W	= 2;
	localparam int PAGE_W	= 12;

	logic					bus_cycle;
	logic [REGION_W-1:0]	region;
	logic [PAGE_W-1:0]		page;
	map_pkg::target_e		target;

	assign bus_cycle	= cyc_i & stb_i;
	assign region		= adr_i[`SOC_ADR_W-1 -: REGION_W];		// byte address 15:14
	assign page			= adr_i[`SOC_ADR_W-1 -: PAGE_W];		// byte address 15:4

	// ##########################################################
	// classify
	// ##########################################################

	always_comb begin
		if (region == `SOC_REGION_RAM0) begin
			target = map_pkg::TGT_PROGMEM;
		end else if (region == `SOC_REGION_RAM1) begin
			target = map_pkg::TGT_VIDMEM;
		end else if (page == `SOC_GPIO_PAGE) begin
			target = map_pkg::TGT_GPIO;
		end else begin
			target = map_pkg::TGT_NONE;
		end
	end

	assign progmem_stb_o	= bus_cycle & (target == map_pkg::TGT_PROGMEM);
	assign vidmem_stb_o		= bus_cycle & (target == map_pkg::TGT_VIDMEM);
	assign gpio_stb_o		= bus_cycle & (target == map_pkg::TGT_GPIO);

	// ##########################################################
	// return path
	// ##########################################################

	always_comb begin
		dat_o = '0;
		ack_o = 1'b0;
		if (bus_cycle) begin
			unique case (target)
				map_pkg::TGT_PROGMEM: begin
					dat_o = progmem_dat_i;
					ack_o = progmem_ack_i;
				end
				map_pkg::TGT_VIDMEM: begin
					dat_o = vidmem_dat_i;
					ack_o = vidmem_ack_i;
				end
				map_pkg::TGT_GPIO: begin
					dat_o = gpio_dat_i;
					ack_o = gpio_ack_i;
				end
				map_pkg::TGT_NONE: begin
					ack_o = 1'b1;		// nobody home, answer now with zero
				end
			endcase
		end
	end

endmodule

/* logic/block_ram.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module block_ram (
	input  logic				clk_i,
	input  logic				reset_i,

	input  logic				stb_i,
	input  logic				we_i,
	input  bus_pkg::ram_adr_t	adr_i,
	input  bus_pkg::sel_t		sel_i,
	input  bus_pkg::dat_t		dat_i,

	output bus_pkg::dat_t		dat_o,
	output logic				ack_o
);

	localparam int DEPTH	= 1 << `SOC_RAM_ADR_W;
	localparam int BYTE_W	= `SOC_DATA_W / `SOC_SEL_W;

	bus_pkg::dat_t	mem [DEPTH];
	bus_pkg::dat_t	rd_q;
	logic			ack_q;
	logic			access;

	// first cycle of a strobe; the second one sees ack_q high
	assign access = stb_i & ~ack_q;

	// ##########################################################
	// handshake
	// ##########################################################

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;		// single-cycle pulse
		end
	end

	// ##########################################################
	// storage
	// ##########################################################

	always_ff @(posedge clk_i) begin
		if (access & we_i) begin
			for (int lane = 0; lane < `SOC_SEL_W; lane++) begin
				if (sel_i[lane]) begin
					mem[adr_i][lane*BYTE_W +: BYTE_W] <= dat_i[lane*BYTE_W +: BYTE_W];
				end
			end
		end
	end

	// read side lands together with the ack
	always_ff @(posedge clk_i) begin
		if (access) begin
			rd_q <= mem[adr_i];		// old word on a write cycle
		end
	end

	assign dat_o = rd_q;
	assign ack_o = ack_q;

endmodule

/* logic/gpio_port.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module gpio_port (
	input  logic						clk_i,
	input  logic						reset_i,

	input  logic						stb_i,
	input  logic						we_i,
	input  bus_pkg::gpio_reg_e			reg_i,
	input  bus_pkg::sel_t				sel_i,
	input  bus_pkg::dat_t				dat_i,
	input  logic [`SOC_GPIO_IN_W-1:0]	pins_i,		// miso, wp, cd

	output bus_pkg::dat_t				dat_o,
	output logic						ack_o,
	output logic						sd_clk_o,
	output logic						sd_mosi_o,
	output logic						sd_cs_o,
	output logic						sd_led_o
);

	localparam int BYTE_W	= `SOC_DATA_W / `SOC_SEL_W;
	localparam int PAD_W	= `SOC_DATA_W - `SOC_GPIO_IN_W;

	logic [`SOC_GPIO_IN_W-1:0]	meta_q;
	logic [`SOC_GPIO_IN_W-1:0]	sync_q;
	bus_pkg::dat_t				out_q;
	bus_pkg::dat_t				rd_q;
	logic [3:0]					pin_q;
	logic						ack_q;
	logic						access;

	assign access = stb_i & ~ack_q;

	// ##########################################################
	// control and pins
	// ##########################################################

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			meta_q	<= '0;
			sync_q	<= '0;
			ack_q	<= 1'b0;
			out_q	<= '0;
			pin_q	<= '0;
		end else begin
			meta_q	<= pins_i;		// async card pins
			sync_q	<= meta_q;
			ack_q	<= access;
			pin_q	<= out_q[3:0];		// drives the card a cycle after the write
			if (access & we_i & (reg_i == bus_pkg::GPIO_OUT)) begin
				for (int lane = 0; lane < `SOC_SEL_W; lane++) begin
					if (sel_i[lane]) begin
						out_q[lane*BYTE_W +: BYTE_W] <= dat_i[lane*BYTE_W +: BYTE_W];
					end
				end
			end
		end
	end

	// readback, valid alongside the ack
	always_ff @(posedge clk_i) begin
		if (access) begin
			unique case (reg_i)
				bus_pkg::GPIO_IN:	rd_q <= {{PAD_W{1'b0}}, sync_q};
				bus_pkg::GPIO_OUT:	rd_q <= out_q;
			endcase
		end
	end

	assign dat_o		= rd_q;
	assign ack_o		= ack_q;
	assign sd_clk_o		= pin_q[3];
	assign sd_mosi_o	= pin_q[2];
	assign sd_cs_o		= pin_q[1];
	assign sd_led_o		= pin_q[0];

endmodule

/* logic/soc_top.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_top (
	input  logic				clk_i,
	input  logic				reset_i,

	// bus from the external master
	input  logic				cyc_i,
	input  logic				stb_i,
	input  logic				we_i,
	input  bus_pkg::adr_t		adr_i,
	input  bus_pkg::sel_t		sel_i,
	input  bus_pkg::dat_t		dat_i,
	output bus_pkg::dat_t		dat_o,
	output logic				ack_o,

	// SD card socket
	input  logic				sd_miso_i,
	input  logic				sd_wp_i,
	input  logic				sd_cd_i,
	output logic				sd_clk_o,
	output logic				sd_mosi_o,
	output logic				sd_cs_o,
	output logic				sd_led_o
);

	logic				progmem_stb;
	logic				progmem_ack;
	bus_pkg::dat_t		progmem_dat;

	logic				vidmem_stb;
	logic				vidmem_ack;
	bus_pkg::dat_t		vidmem_dat;

	logic				gpio_stb;
	logic				gpio_ack;
	bus_pkg::dat_t		gpio_dat;

	// ##########################################################
	// address decode and return mux
	// ##########################################################

	bus_decoder u_decoder (
		.cyc_i			(cyc_i),
		.stb_i			(stb_i),
		.adr_i			(adr_i),
		.progmem_dat_i	(progmem_dat),
		.vidmem_dat_i	(vidmem_dat),
		.gpio_dat_i		(gpio_dat),
		.progmem_ack_i	(progmem_ack),
		.vidmem_ack_i	(vidmem_ack),
		.gpio_ack_i		(gpio_ack),
		.progmem_stb_o	(progmem_stb),
		.vidmem_stb_o	(vidmem_stb),
		.gpio_stb_o		(gpio_stb),
		.dat_o			(dat_o),
		.ack_o			(ack_o)
	);

	// ##########################################################
	// slaves
	// ##########################################################

	block_ram u_progmem (
		.clk_i		(clk_i),
		.reset_i	(reset_i),
		.stb_i		(progmem_stb),
		.we_i		(we_i),
		.adr_i		(adr_i[`SOC_RAM_ADR_W-1:0]),
		.sel_i		(sel_i),
		.dat_i		(dat_i),
		.dat_o		(progmem_dat),
		.ack_o		(progmem_ack)
	);

	block_ram u_vidmem (
		.clk_i		(clk_i),
		.reset_i	(reset_i),
		.stb_i		(vidmem_stb),
		.we_i		(we_i),
		.adr_i		(adr_i[`SOC_RAM_ADR_W-1:0]),
		.sel_i		(sel_i),
		.dat_i		(dat_i),
		.dat_o		(vidmem_dat),
		.ack_o		(vidmem_ack)
	);

	gpio_port u_gpio (
		.clk_i		(clk_i),
		.reset_i	(reset_i),
		.stb_i		(gpio_stb),
		.we_i		(we_i),
		.reg_i		(bus_pkg::gpio_reg_e'(adr_i[0])),		// byte address bit 1
		.sel_i		(sel_i),
		.dat_i		(dat_i),
		.pins_i		({sd_miso_i, sd_wp_i, sd_cd_i}),
		.dat_o		(gpio_dat),
		.ack_o		(gpio_ack),
		.sd_clk_o	(sd_clk_o),
		.sd_mosi_o	(sd_mosi_o),
		.sd_cs_o	(sd_cs_o),
		.sd_led_o	(sd_led_o)
	);

endmodule

/* verif/soc_checker.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_checker (
	input  logic						clk_i,
	input  logic						reset_i,
	input  logic						cyc_i,
	input  logic						stb_i,
	input  logic						we_i,
	input  bus_pkg::adr_t				adr_i,
	input  bus_pkg::sel_t				sel_i,
	input  bus_pkg::dat_t				dat_i,
	input  bus_pkg::dat_t				rd_dat_i,		// dut dat_o
	input  logic						ack_i,
	input  logic [`SOC_GPIO_IN_W-1:0]	sd_in_i,		// miso, wp, cd
	input  logic [3:0]					sd_out_i,		// clk, mosi, cs, led
	output int							err_count_o,
	output int							check_count_o
);

	localparam int DEPTH = 1 << `SOC_RAM_ADR_W;

	bus_pkg::dat_t	prog_model [DEPTH];
	bus_pkg::dat_t	vid_model [DEPTH];
	bus_pkg::dat_t	out_model;
	bus_pkg::dat_t	expected;
	logic [15:0]	byte_adr;
	int				wait_cycles;		// strobe cycles so far without an ack

	initial begin
		err_count_o		= 0;
		check_count_o	= 0;
		out_model		= '0;
		wait_cycles		= 0;
	end

	function automatic bus_pkg::dat_t merge_lanes(input bus_pkg::dat_t old_word,
			input bus_pkg::dat_t new_word, input bus_pkg::sel_t sel);
		bus_pkg::dat_t merged;
		merged = old_word;
		if (sel[1])
			merged[15:8] = new_word[15:8];
		if (sel[0])
			merged[7:0] = new_word[7:0];
		return merged;
	endfunction

	// reference for a read, from the byte address map
	function automatic bus_pkg::dat_t expected_read(input bus_pkg::adr_t adr,
			input logic [2:0] pins);
		logic [15:0] b;
		b = {adr, 1'b0};
		if (b < 16'h4000)
			return prog_model[b[13:1]];
		if (b >= 16'hC000)
			return vid_model[b[13:1]];
		if (b[15:4] == 12'hB01)
			return b[1] ? out_model : {13'd0, pins};		// B012 latch, B010 pins
		return '0;		// hole in the map
	endfunction

	// mapped slaves answer in the second strobe cycle, holes in the first
	function automatic int expected_wait(input bus_pkg::adr_t adr);
		logic [15:0] b;
		b = {adr, 1'b0};
		if (b < 16'h4000 || b >= 16'hC000 || b[15:4] == 12'hB01)
			return 1;
		return 0;
	endfunction

	task automatic report_mismatch(input string name, input logic [15:0] exp,
			input logic [15:0] got);
		$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
		err_count_o++;
	endtask

	// ############################################################
	// compare on each rising edge, pre-edge values
	// ############################################################

	always @(posedge clk_i) begin
		if (reset_i) begin
			out_model = '0;
			wait_cycles = 0;
		end else begin
			if (sd_out_i !== out_model[3:0])
				report_mismatch("sd_clk_o,sd_mosi_o,sd_cs_o,sd_led_o", out_model[3:0],
					sd_out_i);
			if (ack_i !== 1'b0 && !(cyc_i && stb_i))
				report_mismatch("ack_o", 1'b0, ack_i);
			if (cyc_i && stb_i && ack_i === 1'b1) begin
				byte_adr = {adr_i, 1'b0};
				if (wait_cycles != expected_wait(adr_i)) begin
					$display("error at %0t: ack_o came %0d cycles into the strobe, expected %0d",
						$time, wait_cycles, expected_wait(adr_i));
					err_count_o++;
				end
				if (we_i) begin
					if (byte_adr < 16'h4000)
						prog_model[byte_adr[13:1]] =
							merge_lanes(prog_model[byte_adr[13:1]], dat_i, sel_i);
					else if (byte_adr >= 16'hC000)
						vid_model[byte_adr[13:1]] =
							merge_lanes(vid_model[byte_adr[13:1]], dat_i, sel_i);
					else if (byte_adr[15:4] == 12'hB01 && byte_adr[1])
						out_model = merge_lanes(out_model, dat_i, sel_i);
				end else begin
					check_count_o++;
					expected = expected_read(adr_i, sd_in_i);
					if (rd_dat_i !== expected)
						report_mismatch("dat_o", expected, rd_dat_i);
				end
				wait_cycles = 0;
			end else if (cyc_i && stb_i) begin
				wait_cycles++;
			end else begin
				wait_cycles = 0;
			end
		end
	end

endmodule

/* verif/tb_soc_top.sv */
`timescale 1ns/1ps

module tb_soc_top;

	localparam int CLK_PERIOD	= 20;
	localparam int ACK_TIMEOUT	= 20;		// cycles
	localparam int N_WORDS		= 8;

	// word addresses, byte address shifted right by one
	localparam bus_pkg::adr_t GPIO_IN_ADR	= 15'h5808;		// B010
	localparam bus_pkg::adr_t GPIO_OUT_ADR	= 15'h5809;		// B012
	localparam bus_pkg::adr_t KBD_ADR		= 15'h5800;		// B000, unmapped now
	localparam bus_pkg::adr_t HOLE_ADR		= 15'h4000;		// 8000

	logic				clk, reset, cyc, stb, we, ack;
	bus_pkg::adr_t		adr;
	bus_pkg::sel_t		sel;
	bus_pkg::dat_t		wr_dat, rd_dat;
	logic				sd_miso, sd_wp, sd_cd;
	logic				sd_clk, sd_mosi, sd_cs, sd_led;
	int					err_count, check_count, timeouts, test_num, errs_before;
	integer				seed;
	logic [31:0]		rnd;
	bus_pkg::ram_adr_t	offs [N_WORDS];

	soc_top u_dut (
		.clk_i(clk), .reset_i(reset),
		.cyc_i(cyc), .stb_i(stb), .we_i(we), .adr_i(adr), .sel_i(sel), .dat_i(wr_dat),
		.dat_o(rd_dat), .ack_o(ack),
		.sd_miso_i(sd_miso), .sd_wp_i(sd_wp), .sd_cd_i(sd_cd),
		.sd_clk_o(sd_clk), .sd_mosi_o(sd_mosi), .sd_cs_o(sd_cs), .sd_led_o(sd_led)
	);

	soc_checker u_checker (
		.clk_i(clk), .reset_i(reset),
		.cyc_i(cyc), .stb_i(stb), .we_i(we), .adr_i(adr), .sel_i(sel), .dat_i(wr_dat),
		.rd_dat_i(rd_dat), .ack_i(ack),
		.sd_in_i({sd_miso, sd_wp, sd_cd}),
		.sd_out_i({sd_clk, sd_mosi, sd_cs, sd_led}),
		.err_count_o(err_count), .check_count_o(check_count)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic bus_pkg::adr_t prog_adr(input bus_pkg::ram_adr_t off);
		return {2'b00, off};
	endfunction

	function automatic bus_pkg::adr_t vid_adr(input bus_pkg::ram_adr_t off);
		return {2'b11, off};
	endfunction

	// one strobe, held until ack is seen, then dropped on the next falling edge
	task automatic bus_cycle(input logic write, input bus_pkg::adr_t a,
			input bus_pkg::sel_t s, input bus_pkg::dat_t d);
		int waited;
		logic acked;
		@(negedge clk);		// leaves stb low for a cycle between transfers
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = a;
		sel = s;
		wr_dat = d;
		waited = 0;
		acked = 1'b0;
		while (!acked && waited < ACK_TIMEOUT) begin
			#(CLK_PERIOD / 4);		// mid low phase, return path settled
			if (ack === 1'b1) begin
				acked = 1'b1;
			end else begin
				waited++;
				@(negedge clk);
			end
		end
		if (!acked) begin
			$display("timeout: no acknowledge for the cycle at word address %h", a);
			timeouts++;
		end else begin
			@(negedge clk);		// acknowledging edge has passed
		end
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic bus_write(input bus_pkg::adr_t a, input bus_pkg::sel_t s,
			input bus_pkg::dat_t d);
		bus_cycle(1'b1, a, s, d);
	endtask

	task automatic bus_read(input bus_pkg::adr_t a);
		bus_cycle(1'b0, a, 2'b11, '0);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic finish_test(input string name);
		int now;
		test_num++;
		now = err_count + timeouts;
		if (now == errs_before)
			$display("test %0d %s: pass", test_num, name);
		else
			$display("test %0d %s: fail with %0d new errors", test_num, name, now - errs_before);
		errs_before = now;
	endtask

	initial begin
		seed = 32'h51d0;
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		sel = '0;
		wr_dat = '0;
		sd_miso = 1'b0;
		sd_wp = 1'b0;
		sd_cd = 1'b0;
		timeouts = 0;
		test_num = 0;
		errs_before = 0;
		repeat (5) @(negedge clk);
		reset = 1'b0;

		idle_cycles(4);		// checker watches ack and the pins
		finish_test("after reset");

		for (int i = 0; i < N_WORDS; i++) begin
			rnd = $random(seed);
			offs[i] = rnd[12:0];
			rnd = $random(seed);
			bus_write(prog_adr(offs[i]), 2'b11, rnd[15:0]);
			bus_write(vid_adr(offs[i]), 2'b11, rnd[31:16]);		// same offset, other block
		end
		for (int i = 0; i < N_WORDS; i++) begin
			bus_read(prog_adr(offs[i]));
			bus_read(vid_adr(offs[i]));
		end
		finish_test("memory round trip");

		rnd = $random(seed);
		bus_write(prog_adr(13'h0100), 2'b11, rnd[15:0]);
		bus_write(prog_adr(13'h0100), 2'b01, rnd[31:16]);
		bus_read(prog_adr(13'h0100));
		bus_write(vid_adr(13'h1abc), 2'b11, rnd[31:16]);
		bus_write(vid_adr(13'h1abc), 2'b10, rnd[15:0]);
		bus_read(vid_adr(13'h1abc));
		finish_test("byte lanes");

		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			bus_write(GPIO_OUT_ADR, (i == 3) ? 2'b01 : 2'b11, rnd[15:0]);
			bus_read(GPIO_OUT_ADR);
			idle_cycles(2);		// pins follow one cycle after ack
		end
		finish_test("port output register");

		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			sd_miso = rnd[2];
			sd_wp = rnd[1];
			sd_cd = rnd[0];
			idle_cycles(4);
			bus_read(GPIO_IN_ADR);
		end
		bus_write(GPIO_IN_ADR, 2'b11, 16'hffff);		// input register ignores it
		bus_read(GPIO_OUT_ADR);
		bus_read(GPIO_IN_ADR);
		finish_test("port input register");

		// holes alias offsets 1800 and 0000 in the low address bits
		bus_write(prog_adr(13'h0000), 2'b11, 16'h1234);
		bus_write(prog_adr(13'h1800), 2'b11, 16'h5678);
		bus_write(vid_adr(13'h0000), 2'b11, 16'h9abc);
		bus_write(vid_adr(13'h1800), 2'b11, 16'hdef0);
		bus_read(KBD_ADR);
		bus_read(HOLE_ADR);
		bus_write(KBD_ADR, 2'b11, 16'hffff);
		bus_write(HOLE_ADR, 2'b11, 16'haaaa);
		bus_read(prog_adr(13'h0000));
		bus_read(prog_adr(13'h1800));
		bus_read(vid_adr(13'h0000));
		bus_read(vid_adr(13'h1800));
		bus_read(GPIO_OUT_ADR);
		bus_read(KBD_ADR);
		bus_read(HOLE_ADR);
		finish_test("unmapped address");

		idle_cycles(2);
		$display("totals: %0d reads checked, %0d errors, %0d timeouts",
			check_count, err_count, timeouts);
		if (err_count == 0 && timeouts == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* soc_top.f */
+incdir+logic
logic/bus_pkg.sv
logic/map_pkg.sv
logic/bus_decoder.sv
logic/block_ram.sv
logic/gpio_port.sv
logic/soc_top.sv
verif/soc_checker.sv
verif/tb_soc_top.sv
